// ==== fp_addsub_macros.svh ====
//////////////////////////////////////////////////////////////////////
// fp add/sub widths and sizing
// single precision field widths, exponent bias and lane count
//////////////////////////////////////////////////////////////////////

`ifndef FP_ADDSUB_MACROS_SVH
`define FP_ADDSUB_MACROS_SVH

// ieee single fields
`define FP_EXP_W 8
`define FP_MAN_W 23
`define FP_BIAS  127

// parallel datapath lanes, 2 or more
`define N_LANES  4

`endif

// ==== logic/fp_addsub_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// fp add/sub shared types
// words, operations, flags, results and the lane controller states
//////////////////////////////////////////////////////////////////////

`include "fp_addsub_macros.svh"

package fp_addsub_pkg;

  typedef struct packed {
    logic                 sign;
    logic [`FP_EXP_W-1:0] exp;
    logic [`FP_MAN_W-1:0] frac;
  } fp_word_t;

  typedef struct packed {
    fp_word_t a;
    fp_word_t b;
    logic     sub;   // 1 selects a - b
  } fp_op_t;

  typedef struct packed {
    logic overflow;
    logic underflow;
    logic inexact;
  } fp_flags_t;

  typedef struct packed {
    fp_word_t  value;
    fp_flags_t flags;
  } fp_res_t;

  typedef enum logic [2:0] {
    IDLE,
    PRE_NORMALIZING,
    OPERATION,
    NORMALIZING,
    SHIFTING_EXPONENT,
    ROUNDING,
    RESULT,
    RELEASE
  } lane_state_t;

endpackage

// ==== logic/fp_chan_if.sv ====
//////////////////////////////////////////////////////////////////////
// four-phase req/ack channel
// payload type is set per instance, operations or results
//////////////////////////////////////////////////////////////////////

interface fp_chan_if #(
  parameter type payload_t = logic
) ();

  logic     req;
  logic     ack;
  payload_t payload;   // held stable while req is high

  modport source (
    output req,
    output payload,
    input  ack
  );

  modport sink (
    input  req,
    input  payload,
    output ack
  );

endinterface

// ==== logic/add_sub_fsm.sv ====
//////////////////////////////////////////////////////////////////////
// lane controller
// walks the fixed add/sub sequence, one load enable per working state
//////////////////////////////////////////////////////////////////////

module add_sub_fsm
  import fp_addsub_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        start,
  input  logic        out_ack,
  output lane_state_t state,
  output logic        load_operands,
  output logic        load_aligned,
  output logic        load_sum,
  output logic        load_normalized,
  output logic        load_result,
  output logic        done
);

  lane_state_t next;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= next;
    end
  end

  always_comb begin
    next = state;
    case (state)
      IDLE:              next = start ? PRE_NORMALIZING : IDLE;
      PRE_NORMALIZING:   next = OPERATION;
      OPERATION:         next = NORMALIZING;
      NORMALIZING:       next = SHIFTING_EXPONENT;
      SHIFTING_EXPONENT: next = ROUNDING;
      ROUNDING:          next = RESULT;
      RESULT:            next = out_ack ? RELEASE : RESULT;   // collector took it
      RELEASE:           next = out_ack ? RELEASE : IDLE;     // wait for ack low
      default:           next = IDLE;
    endcase
  end

  always_comb begin
    load_operands   = 1'b0;
    load_aligned    = 1'b0;
    load_sum        = 1'b0;
    load_normalized = 1'b0;
    load_result     = 1'b0;
    done            = 1'b0;
    case (state)
      PRE_NORMALIZING:   load_operands   = 1'b1;
      OPERATION:         load_aligned    = 1'b1;
      NORMALIZING:       load_sum        = 1'b1;
      SHIFTING_EXPONENT: load_normalized = 1'b1;
      ROUNDING:          load_result     = 1'b1;
      RESULT:            done            = 1'b1;
      default: begin
      end
    endcase
  end

endmodule

// ==== logic/fp_addsub_lane.sv ====
//////////////////////////////////////////////////////////////////////
// fp add/sub lane
// sequenced single precision datapath between two req/ack channels
//////////////////////////////////////////////////////////////////////

`include "fp_addsub_macros.svh"

module fp_addsub_lane
  import fp_addsub_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  fp_chan_if.sink   issue,
  fp_chan_if.source result
);

  localparam int E_W     = `FP_EXP_W;
  localparam int M_W     = `FP_MAN_W + 1;       // with hidden bit
  localparam int A_W     = M_W + 3;             // plus guard, round, sticky
  localparam int LZ_W    = $clog2(A_W + 1);
  localparam int EXP_MAX = 2 * `FP_BIAS + 1;

  lane_state_t state;
  logic start, ack_q;
  logic load_operands, load_aligned, load_sum, load_normalized, load_result, done;

  fp_op_t            op_q;
  fp_word_t          b_eff;
  logic [E_W+M_W-2:0] mag_a, mag_b;
  logic [M_W-1:0]    mant_a, mant_b;
  logic              swap;
  logic              l_sign, s_sign;
  logic [E_W-1:0]    l_exp, s_exp, exp_diff;
  logic [M_W-1:0]    l_mant, s_mant;
  logic [A_W-1:0]    s_ext, s_shift, s_mask, small_al;
  logic              s_sticky, sub_r, sign_r;
  logic [A_W:0]      sum;
  logic [LZ_W-1:0]   lz, lz_r;
  logic [A_W-1:0]    norm_mant;
  logic              carry_r, zero_r, uf_r;
  logic signed [E_W+1:0] exp_adj, exp_r, exp_fin;
  logic [M_W-1:0]    mant_keep;
  logic [M_W:0]      mant_rnd;
  logic              guard, round_bit, sticky, lost, round_up;
  fp_res_t           res_next, res_q;

  function automatic logic [LZ_W-1:0] count_lz(input logic [A_W-1:0] v);
    logic [LZ_W-1:0] n;
    n = LZ_W'(A_W);
    for (int i = 0; i < A_W; i++) begin
      if (v[i]) begin
        n = LZ_W'(A_W - 1 - i);
      end
    end
    return n;
  endfunction

  add_sub_fsm fsm_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .start           (start),
    .out_ack         (result.ack),
    .state           (state),
    .load_operands   (load_operands),
    .load_aligned    (load_aligned),
    .load_sum        (load_sum),
    .load_normalized (load_normalized),
    .load_result     (load_result),
    .done            (done)
  );

  //////////////////////////////////////////////////////////////////////
  // issue side
  assign start = (state == IDLE) & issue.req & ~ack_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= issue.req & (ack_q | start);   // hold until req falls
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      op_q <= issue.payload;
    end
  end

  assign issue.ack      = ack_q;
  assign result.req     = done;
  assign result.payload = res_q;

  //////////////////////////////////////////////////////////////////////
  // pre-normalize and align
  always_comb begin
    b_eff      = op_q.b;
    b_eff.sign = op_q.b.sign ^ op_q.sub;
    mant_a     = (op_q.a.exp == '0) ? '0 : {1'b1, op_q.a.frac};   // subnormal reads as 0
    mant_b     = (op_q.b.exp == '0) ? '0 : {1'b1, op_q.b.frac};
    mag_a      = (op_q.a.exp == '0) ? '0 : {op_q.a.exp, op_q.a.frac};
    mag_b      = (op_q.b.exp == '0) ? '0 : {op_q.b.exp, op_q.b.frac};
    swap       = mag_b > mag_a;
  end

  always_ff @(posedge clk) begin
    if (load_operands) begin
      l_sign <= swap ? b_eff.sign : op_q.a.sign;
      l_exp  <= swap ? b_eff.exp : op_q.a.exp;
      l_mant <= swap ? mant_b : mant_a;
      s_sign <= swap ? op_q.a.sign : b_eff.sign;
      s_exp  <= swap ? op_q.a.exp : b_eff.exp;
      s_mant <= swap ? mant_a : mant_b;
    end
  end

  always_comb begin
    exp_diff = l_exp - s_exp;
    s_ext    = {s_mant, 3'b000};
    s_mask   = (A_W'(1) << exp_diff) - A_W'(1);
    if (exp_diff >= E_W'(A_W)) begin
      s_shift  = '0;
      s_sticky = |s_mant;                     // shifted fully out
    end else begin
      s_shift  = s_ext >> exp_diff;
      s_sticky = |(s_ext & s_mask);
    end
  end

  always_ff @(posedge clk) begin
    if (load_aligned) begin
      small_al <= {s_shift[A_W-1:1], s_shift[0] | s_sticky};
      sub_r    <= l_sign ^ s_sign;              // effective operation
      sign_r   <= l_sign;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // add/subtract, normalize, exponent
  always_comb begin
    if (sub_r) begin
      sum = {1'b0, l_mant, 3'b000} - {1'b0, small_al};
    end else begin
      sum = {1'b0, l_mant, 3'b000} + {1'b0, small_al};
    end
    lz = count_lz(sum[A_W-1:0]);
  end

  always_ff @(posedge clk) begin
    if (load_sum) begin
      carry_r <= sum[A_W];
      zero_r  <= (sum == '0);
      lz_r    <= sum[A_W] ? '0 : lz;
      if (sum[A_W]) begin
        norm_mant <= {sum[A_W:2], sum[1] | sum[0]};   // keep sticky on right shift
      end else begin
        norm_mant <= sum[A_W-1:0] << lz;
      end
    end
  end

  assign exp_adj = {2'b00, l_exp} + (E_W+2)'(carry_r) - (E_W+2)'(lz_r);

  always_ff @(posedge clk) begin
    if (load_normalized) begin
      exp_r <= exp_adj;
      uf_r  <= ~zero_r & (exp_adj <= 0);        // tiny, flushed later
    end
  end

  //////////////////////////////////////////////////////////////////////
  // round to nearest even and pack
  always_comb begin
    mant_keep = norm_mant[A_W-1:3];
    guard     = norm_mant[2];
    round_bit = norm_mant[1];
    sticky    = norm_mant[0];
    lost      = guard | round_bit | sticky;
    round_up  = guard & (round_bit | sticky | mant_keep[0]);
    mant_rnd  = {1'b0, mant_keep} + (M_W+1)'(round_up);
    exp_fin   = exp_r + (E_W+2)'(mant_rnd[M_W]);   // carry out of rounding
    res_next  = '0;
    if (zero_r) begin
      res_next.value.sign = sign_r & ~sub_r;        // exact cancel gives +0
    end else if (uf_r) begin
      res_next.value.sign      = sign_r;
      res_next.flags.underflow = 1'b1;
      res_next.flags.inexact   = 1'b1;
    end else if (exp_fin >= EXP_MAX) begin
      res_next.value.sign     = sign_r;
      res_next.value.exp      = '1;
      res_next.flags.overflow = 1'b1;
      res_next.flags.inexact  = 1'b1;
    end else begin
      res_next.value.sign    = sign_r;
      res_next.value.exp     = exp_fin[E_W-1:0];
      res_next.value.frac    = mant_rnd[M_W] ? mant_rnd[M_W-1:1] : mant_rnd[M_W-2:0];
      res_next.flags.inexact = lost;
    end
  end

  always_ff @(posedge clk) begin
    if (load_result) begin
      res_q <= res_next;
    end
  end

endmodule

// ==== logic/op_dispatch.sv ====
//////////////////////////////////////////////////////////////////////
// operation dispatcher
// bridges the input handshake to the lanes in round-robin order
//////////////////////////////////////////////////////////////////////

`include "fp_addsub_macros.svh"

module op_dispatch
  import fp_addsub_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      in_req,
  output logic      in_ack,
  input  fp_op_t    in_op,
  fp_chan_if.source lanes [`N_LANES]
);

  localparam int PTR_W = $clog2(`N_LANES);

  typedef enum logic [1:0] {
    D_IDLE,
    D_ISSUE,
    D_HOLD
  } disp_state_t;

  disp_state_t          state;
  logic [PTR_W-1:0]     ptr;
  logic                 req_q;
  fp_op_t               op_q;
  logic [`N_LANES-1:0]  lane_ack;

  for (genvar i = 0; i < `N_LANES; i++) begin : g_lane
    assign lanes[i].req     = req_q & (ptr == PTR_W'(i));
    assign lanes[i].payload = op_q;
    assign lane_ack[i]      = lanes[i].ack;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state  <= D_IDLE;
      ptr    <= '0;
      req_q  <= 1'b0;
      in_ack <= 1'b0;
    end else begin
      case (state)
        D_IDLE: begin
          if (in_req) begin
            req_q <= 1'b1;
            state <= D_ISSUE;
          end
        end
        D_ISSUE: begin
          if (lane_ack[ptr]) begin              // lane has latched the op
            req_q  <= 1'b0;
            in_ack <= 1'b1;
            state  <= D_HOLD;
          end
        end
        D_HOLD: begin
          if (!in_req && !lane_ack[ptr]) begin
            in_ack <= 1'b0;
            ptr    <= (ptr == PTR_W'(`N_LANES - 1)) ? '0 : ptr + 1'b1;
            state  <= D_IDLE;
          end
        end
        default: state <= D_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == D_IDLE && in_req) begin
      op_q <= in_op;
    end
  end

endmodule

// ==== logic/result_collect.sv ====
//////////////////////////////////////////////////////////////////////
// result collector
// drains the lanes in issue order onto the output handshake
//////////////////////////////////////////////////////////////////////

`include "fp_addsub_macros.svh"

module result_collect
  import fp_addsub_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  fp_chan_if.sink  lanes [`N_LANES],
  output logic     out_req,
  input  logic     out_ack,
  output fp_res_t  out_res
);

  localparam int PTR_W = $clog2(`N_LANES);

  typedef enum logic [1:0] {
    C_WAIT,
    C_ACK,
    C_LANE,
    C_OUT
  } coll_state_t;

  coll_state_t          state;
  logic [PTR_W-1:0]     ptr;
  logic                 ack_q;
  logic [`N_LANES-1:0]  lane_req;
  fp_res_t              lane_res [`N_LANES];

  for (genvar i = 0; i < `N_LANES; i++) begin : g_lane
    assign lane_req[i]  = lanes[i].req;
    assign lane_res[i]  = lanes[i].payload;
    assign lanes[i].ack = ack_q & (ptr == PTR_W'(i));
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= C_WAIT;
      ptr     <= '0;
      ack_q   <= 1'b0;
      out_req <= 1'b0;
    end else begin
      case (state)
        C_WAIT: begin
          if (lane_req[ptr]) begin
            out_req <= 1'b1;
            state   <= C_ACK;
          end
        end
        C_ACK: begin
          ack_q <= 1'b1;                        // one cycle after out_req
          state <= C_LANE;
        end
        C_LANE: begin
          if (!lane_req[ptr]) begin
            ack_q <= 1'b0;
            state <= C_OUT;
          end
        end
        C_OUT: begin
          if (!out_req && !out_ack) begin      // output handshake finished
            ptr   <= (ptr == PTR_W'(`N_LANES - 1)) ? '0 : ptr + 1'b1;
            state <= C_WAIT;
          end
        end
        default: state <= C_WAIT;
      endcase
      if (out_req && out_ack) begin
        out_req <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == C_WAIT && lane_req[ptr]) begin
      out_res <= lane_res[ptr];
    end
  end

endmodule

// ==== logic/fp_addsub_top.sv ====
//////////////////////////////////////////////////////////////////////
// multi-lane fp adder/subtractor
// dispatcher, parallel lanes and in-order collector
//////////////////////////////////////////////////////////////////////

`include "fp_addsub_macros.svh"

module fp_addsub_top
  import fp_addsub_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    in_req,
  output logic    in_ack,
  input  fp_op_t  in_op,
  output logic    out_req,
  input  logic    out_ack,
  output fp_res_t out_res
);

  fp_chan_if #(.payload_t(fp_op_t))  issue_ch [`N_LANES] ();
  fp_chan_if #(.payload_t(fp_res_t)) done_ch  [`N_LANES] ();

  op_dispatch dispatch_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .in_req (in_req),
    .in_ack (in_ack),
    .in_op  (in_op),
    .lanes  (issue_ch)
  );

  for (genvar g = 0; g < `N_LANES; g++) begin : g_lanes
    fp_addsub_lane lane_i (
      .clk    (clk),
      .rst_n  (rst_n),
      .issue  (issue_ch[g]),
      .result (done_ch[g])
    );
  end

  result_collect collect_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .lanes   (done_ch),
    .out_req (out_req),
    .out_ack (out_ack),
    .out_res (out_res)
  );

endmodule

// ==== test/fp_addsub_sva.sv ====
//////////////////////////////////////////////////////////////////////
// lane assertions
// four-phase handshakes on both channels and controller stepping
//////////////////////////////////////////////////////////////////////

module fp_addsub_sva
  import fp_addsub_pkg::*;
(
  input logic        clk,
  input logic        rst_n,
  input lane_state_t state,
  input logic        issue_req,
  input logic        issue_ack,
  input fp_op_t      issue_payload,
  input logic        result_req,
  input logic        result_ack,
  input fp_res_t     result_payload
);

  issue_req_held: assert property (@(posedge clk) disable iff (!rst_n)
    issue_req && !issue_ack |=> issue_req)
    else $error("issue req fell before ack");

  result_req_held: assert property (@(posedge clk) disable iff (!rst_n)
    result_req && !result_ack |=> result_req)
    else $error("result req fell before ack");

  issue_payload_stable: assert property (@(posedge clk) disable iff (!rst_n)
    issue_req |=> !issue_req || $stable(issue_payload))
    else $error("issue payload changed while req was high");

  result_payload_stable: assert property (@(posedge clk) disable iff (!rst_n)
    result_req |=> !result_req || $stable(result_payload))
    else $error("result payload changed while req was high");

  // working states last exactly one cycle
  state_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    state inside {PRE_NORMALIZING, OPERATION, NORMALIZING, SHIFTING_EXPONENT, ROUNDING}
    |=> state != $past(state))
    else $error("controller stayed in a working state");

endmodule

bind fp_addsub_lane fp_addsub_sva sva_i (
  .clk            (clk),
  .rst_n          (rst_n),
  .state          (state),
  .issue_req      (issue.req),
  .issue_ack      (issue.ack),
  .issue_payload  (issue.payload),
  .result_req     (result.req),
  .result_ack     (result.ack),
  .result_payload (result.payload)
);

// ==== test/fp_addsub_tb.sv ====
//////////////////////////////////////////////////////////////////////
// fp add/sub testbench
// file-driven operations, random output back-pressure, in-order checks
//////////////////////////////////////////////////////////////////////

module fp_addsub_tb
  import fp_addsub_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 1000;
  localparam int QUIET_CYCLES   = 40;

  logic    clk;
  logic    rst_n;
  logic    in_req;
  logic    in_ack;
  fp_op_t  in_op;
  logic    out_req;
  logic    out_ack;
  fp_res_t out_res;
  logic    out_req_d;

  fp_op_t  ops [$];        // issue order
  fp_res_t expected [$];   // same order as ops
  int      seed;
  int      n_results;

  fp_addsub_top dut_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_req  (in_req),
    .in_ack  (in_ack),
    .in_op   (in_op),
    .out_req (out_req),
    .out_ack (out_ack),
    .out_res (out_res)
  );

  always #4 clk = ~clk;

  // rising edges of out_req, one per result leaving the DUT
  always @(posedge clk) begin
    if (out_req && !out_req_d) begin
      n_results <= n_results + 1;
    end
    out_req_d <= out_req;
  end

  //////////////////////////////////////////////////////////////////////
  // failure and compare helpers
  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_word(input string name, input fp_word_t got, input fp_word_t want);
    if (got !== want) begin
      $display("[ERROR] %s got %h expected %h", name, got, want);
      abort_run();
    end
  endtask

  task automatic check_flags(input string name, input fp_flags_t got, input fp_flags_t want);
    if (got !== want) begin
      $display("[ERROR] %s got %h expected %h", name, got, want);
      abort_run();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // bounded waits, outputs sampled at the rising edge before update
  task automatic wait_in_ack(input logic level);
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        $display("timed out waiting for in_ack to become %0b", level);
        abort_run();
      end
    end while (in_ack !== level);
  endtask

  task automatic wait_out_req(input logic level);
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        $display("timed out waiting for out_req to become %0b", level);
        abort_run();
      end
    end while (out_req !== level);
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus
  task automatic load_stimulus();
    int          fd;
    int          n;
    string       line;
    logic [31:0] a, b, value;
    logic [3:0]  sub, flags;
    fp_op_t      op;
    fp_res_t     res;
    fd = $fopen("test/fp_addsub_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file");
      abort_run();
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.substr(0, 1) != "//") begin
          n = $sscanf(line, "%h %h %h %h %h", a, b, sub, value, flags);
          if (n == 5) begin
            op.a      = a;
            op.b      = b;
            op.sub    = sub[0];
            res.value = value;
            res.flags = flags[2:0];
            ops.push_back(op);
            expected.push_back(res);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic send_ops();
    for (int i = 0; i < ops.size(); i++) begin
      in_op  <= ops[i];
      in_req <= 1'b1;
      wait_in_ack(1'b1);
      in_req <= 1'b0;
      wait_in_ack(1'b0);   // ready for the next operation
    end
  endtask

  task automatic receive_results();
    int delay;
    for (int i = 0; i < expected.size(); i++) begin
      wait_out_req(1'b1);
      delay = $unsigned($random(seed)) % 6;   // 0..5 cycles of back-pressure
      repeat (delay) @(posedge clk);
      check_word("out_res.value", out_res.value, expected[i].value);
      check_flags("out_res.flags", out_res.flags, expected[i].flags);
      out_ack <= 1'b1;
      wait_out_req(1'b0);
      out_ack <= 1'b0;
    end
  endtask

  task automatic check_quiet_output();
    repeat (QUIET_CYCLES) begin
      @(posedge clk);
      if (out_req) begin
        $display("out_req rose again after the last expected result");
        abort_run();
      end
    end
  endtask

  initial begin
    seed      = 45619;
    n_results = 0;
    clk       = 1'b0;
    rst_n     = 1'b0;
    in_req    = 1'b0;
    in_op     = '0;
    out_ack   = 1'b0;
    load_stimulus();
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    fork
      send_ops();
      receive_results();
    join
    check_quiet_output();
    if (n_results == ops.size() && n_results > 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("got %0d results for %0d stimulus lines", n_results, ops.size());
      abort_run();
    end
  end

endmodule

// ==== test/fp_addsub_stimulus.txt ====
// columns: a b sub expected_value expected_flags, all hex
// flags: bit2 overflow, bit1 underflow, bit0 inexact
3f800000 40000000 0 40400000 0
3fc00000 3fc00000 0 40400000 0
c0200000 bf000000 0 c0400000 0
3f800000 3f800000 1 00000000 0
bf800000 3f800000 0 00000000 0
40400000 3f800000 1 40000000 0
3f800000 3f400000 1 3e800000 0
3f000000 40000000 1 bfc00000 0
40200000 bf000000 1 40400000 0
3f800000 30800000 0 3f800000 1
3f800000 30800000 1 3f800000 1
3f800000 33800000 0 3f800000 1
3f800001 33800000 0 3f800002 1
3fffffff 33800000 0 40000000 1
3f800000 3f800003 0 40000002 1
7f7fffff 7f7fffff 0 7f800000 5
ff7fffff 7f7fffff 1 ff800000 5
00c00000 00800000 1 00000000 3
80c00000 00800000 0 80000000 3
00000000 40a00000 0 40a00000 0
80000000 80000000 0 80000000 0

// ==== fp_addsub.f ====
+incdir+.
logic/fp_addsub_pkg.sv
logic/fp_chan_if.sv
logic/add_sub_fsm.sv
logic/fp_addsub_lane.sv
logic/op_dispatch.sv
logic/result_collect.sv
logic/fp_addsub_top.sv
test/fp_addsub_sva.sv
test/fp_addsub_tb.sv
